// ==== source/pdu_defs.svh ====
`ifndef PDU_DEFS_SVH
`define PDU_DEFS_SVH

// --------------------
// Datapath
// --------------------

// Data and address width
`define PDU_XLEN 32

// Byte increment between consecutive words
`define PDU_ADDR_STEP 4

// --------------------
// Debug features
// --------------------

// Breakpoint slots
`define PDU_BP_NUM 3

// Clock cycles per UART bit, kept small for simulation
`define PDU_BAUD_DIV 8

`endif

// ==== source/pdu_pkg.sv ====
package pdu_pkg;

`include "pdu_defs.svh"

    typedef logic [`PDU_XLEN-1:0] pdu_word_t;
    typedef logic [7:0]           pdu_byte_t;

    // --------------------
    // Host protocol
    // --------------------
    typedef enum logic [7:0] {
        CMD_READ     = 8'h01,
        CMD_WRITE    = 8'h02,
        CMD_BP_SET   = 8'h03,
        CMD_BP_CLEAR = 8'h04,
        CMD_RUN      = 8'h05
    } pdu_cmd_e;

    typedef enum logic [7:0] {
        REPLY_ACK    = 8'h06,
        REPLY_NAK    = 8'h15,
        REPLY_BP_HIT = 8'h42,
        REPLY_HALT   = 8'h48,
        REPLY_FULL   = 8'hFF
    } pdu_reply_e;

    // Controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ARGS,
        ST_WDATA,
        ST_WB_WRITE,
        ST_WB_READ,
        ST_SEND,
        ST_RUN
    } pdu_state_e;

    // --------------------
    // Buses
    // --------------------
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        pdu_word_t adr;
        pdu_word_t dat;
    } wb_req_t;

    typedef struct packed {
        logic      ack;
        pdu_word_t dat;
    } wb_rsp_t;

    typedef struct packed {
        logic      valid;
        pdu_word_t pc;
        logic      halt;
    } commit_t;

    typedef struct packed {
        logic      valid;
        pdu_byte_t data;
    } byte_stream_t;

endpackage

// ==== source/pdu_uart_rx.sv ====
`include "pdu_defs.svh"

module pdu_uart_rx #(
    parameter int CLKS_PER_BIT = `PDU_BAUD_DIV
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rxd,
    output pdu_pkg::byte_stream_t rx_byte
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    logic             rxd_meta;
    logic             rxd_sync;
    logic             rxd_last;
    logic             busy;
    logic             valid_q;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    logic [7:0]       shift;

    // Two-flop synchronizer plus one stage for the falling edge
    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_last <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_last <= rxd_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            valid_q <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            valid_q <= 1'b0;
            if (!busy) begin
                if (rxd_last && !rxd_sync) begin
                    // Count to the middle of the start bit
                    busy    <= 1'b1;
                    clk_cnt <= CNT_W'(CLKS_PER_BIT / 2 - 1);
                    bit_cnt <= '0;
                end
            end else if (clk_cnt != '0) begin
                clk_cnt <= clk_cnt - 1'b1;
            end else begin
                clk_cnt <= CNT_W'(CLKS_PER_BIT - 1);
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 4'd0 && rxd_sync) begin
                    // Glitch, not a real start bit
                    busy <= 1'b0;
                end else if (bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
                    shift <= {rxd_sync, shift[7:1]};
                end else if (bit_cnt == 4'd9) begin
                    busy    <= 1'b0;
                    valid_q <= rxd_sync;
                end
            end
        end
    end

    assign rx_byte.valid = valid_q;
    assign rx_byte.data  = shift;

endmodule

// ==== source/pdu_uart_tx.sv ====
`include "pdu_defs.svh"

module pdu_uart_tx #(
    parameter int CLKS_PER_BIT = `PDU_BAUD_DIV
) (
    input  logic                  clk,
    input  logic                  rst,
    input  pdu_pkg::byte_stream_t tx_byte,
    output logic                  tx_ready,
    output logic                  txd
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    logic [9:0]       frame;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    logic             busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame   <= '1;
            clk_cnt <= '0;
            bit_cnt <= '0;
            busy    <= 1'b0;
        end else if (!busy) begin
            if (tx_byte.valid) begin
                // Stop bit, data LSB first, start bit
                frame   <= {1'b1, tx_byte.data, 1'b0};
                clk_cnt <= CNT_W'(CLKS_PER_BIT - 1);
                bit_cnt <= 4'd9;
                busy    <= 1'b1;
            end
        end else if (clk_cnt != '0) begin
            clk_cnt <= clk_cnt - 1'b1;
        end else if (bit_cnt == 4'd0) begin
            // End of stop bit
            busy <= 1'b0;
        end else begin
            frame   <= {1'b1, frame[9:1]};
            clk_cnt <= CNT_W'(CLKS_PER_BIT - 1);
            bit_cnt <= bit_cnt - 1'b1;
        end
    end

    assign tx_ready = !busy;
    assign txd      = frame[0];

endmodule

// ==== source/pdu_bp_table.sv ====
`include "pdu_defs.svh"

module pdu_bp_table
    import pdu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      bp_set_en,
    input  logic      bp_clear,
    input  pdu_word_t bp_set_pc,
    input  commit_t   commit,
    output logic [1:0] bp_slot,
    output logic      bp_hit
);

    logic [`PDU_BP_NUM-1:0] bp_valid;
    pdu_word_t              bp_addr [`PDU_BP_NUM];
    logic                   slot_free;

    // Lowest free slot, 3 when full
    always_comb begin
        bp_slot = 2'd3;
        for (int i = `PDU_BP_NUM - 1; i >= 0; i--) begin
            if (!bp_valid[i]) begin
                bp_slot = 2'(i);
            end
        end
    end

    assign slot_free = (bp_slot != 2'd3);

    always_comb begin
        bp_hit = 1'b0;
        for (int i = 0; i < `PDU_BP_NUM; i++) begin
            if (commit.valid && bp_valid[i] && commit.pc == bp_addr[i]) begin
                bp_hit = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || bp_clear) begin
            bp_valid <= '0;
        end else if (bp_set_en && slot_free) begin
            bp_valid[bp_slot] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bp_set_en && slot_free) begin
            bp_addr[bp_slot] <= bp_set_pc;
        end
    end

endmodule

// ==== source/pdu_ctrl.sv ====
`include "pdu_defs.svh"

module pdu_ctrl
    import pdu_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  byte_stream_t rx_byte,
    output byte_stream_t tx_byte,
    input  logic         tx_ready,
    output wb_req_t      wb_req,
    input  wb_rsp_t      wb_rsp,
    input  commit_t      commit,
    input  logic         bp_hit,
    input  logic [1:0]   bp_slot,
    output logic         bp_set_en,
    output logic         bp_clear,
    output pdu_word_t    bp_set_pc,
    output logic         cpu_en
);

    localparam pdu_word_t ZERO_WORD = '0;

    pdu_state_e                state;
    pdu_state_e                ret_state;
    pdu_cmd_e                  op;
    logic [2:0]                byte_cnt;
    pdu_word_t                 shift;
    pdu_word_t                 addr;
    pdu_byte_t                 words_left;
    // Holds a code byte and one reply word shifted out from the top
    logic [`PDU_XLEN+7:0]      tx_buf;
    logic [2:0]                tx_left;
    pdu_word_t                 rx_word;
    logic [2:0]                last_arg;
    logic                      stop_hit;
    pdu_byte_t                 slot_reply;

    assign rx_word    = {shift[`PDU_XLEN-9:0], rx_byte.data};
    assign last_arg   = (op == CMD_BP_SET) ? 3'd3 : 3'd4;
    assign stop_hit   = commit.valid && (bp_hit || commit.halt);
    assign slot_reply = (bp_slot == 2'd3) ? REPLY_FULL : {6'd0, bp_slot};

    // --------------------
    // Outputs
    // --------------------
    assign tx_byte.valid = (state == ST_SEND);
    assign tx_byte.data  = tx_buf[`PDU_XLEN+7 -: 8];

    assign wb_req.cyc = (state == ST_WB_READ) || (state == ST_WB_WRITE);
    assign wb_req.stb = (state == ST_WB_READ) || (state == ST_WB_WRITE);
    assign wb_req.we  = (state == ST_WB_WRITE);
    assign wb_req.adr = addr;
    assign wb_req.dat = shift;

    assign bp_set_en = (state == ST_ARGS) && rx_byte.valid && (op == CMD_BP_SET)
                     && (byte_cnt == last_arg);
    assign bp_set_pc = rx_word;
    assign bp_clear  = (state == ST_IDLE) && rx_byte.valid && (rx_byte.data == CMD_BP_CLEAR);

    // --------------------
    // Command FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            ret_state  <= ST_IDLE;
            byte_cnt   <= '0;
            tx_left    <= '0;
            words_left <= '0;
            cpu_en     <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (rx_byte.valid) begin
                        op       <= pdu_cmd_e'(rx_byte.data);
                        byte_cnt <= '0;
                        case (rx_byte.data)
                            CMD_READ, CMD_WRITE, CMD_BP_SET: begin
                                state <= ST_ARGS;
                            end
                            CMD_BP_CLEAR: begin
                                tx_buf    <= {REPLY_ACK, ZERO_WORD};
                                tx_left   <= 3'd1;
                                ret_state <= ST_IDLE;
                                state     <= ST_SEND;
                            end
                            CMD_RUN: begin
                                tx_buf    <= {REPLY_ACK, ZERO_WORD};
                                tx_left   <= 3'd1;
                                ret_state <= ST_RUN;
                                state     <= ST_SEND;
                            end
                            default: begin
                                tx_buf    <= {REPLY_NAK, ZERO_WORD};
                                tx_left   <= 3'd1;
                                ret_state <= ST_IDLE;
                                state     <= ST_SEND;
                            end
                        endcase
                    end
                end

                // Address or PC followed by the word count
                ST_ARGS: begin
                    if (rx_byte.valid) begin
                        shift    <= rx_word;
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 3'd3) begin
                            addr <= rx_word;
                        end
                        if (byte_cnt == last_arg) begin
                            byte_cnt <= '0;
                            if (op == CMD_BP_SET) begin
                                tx_buf    <= {slot_reply, ZERO_WORD};
                                tx_left   <= 3'd1;
                                ret_state <= ST_IDLE;
                                state     <= ST_SEND;
                            end else begin
                                words_left <= rx_byte.data;
                                state      <= (op == CMD_READ) ? ST_WB_READ : ST_WDATA;
                            end
                        end
                    end
                end

                ST_WDATA: begin
                    if (rx_byte.valid) begin
                        shift    <= rx_word;
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 3'd3) begin
                            byte_cnt <= '0;
                            state    <= ST_WB_WRITE;
                        end
                    end
                end

                ST_WB_WRITE: begin
                    if (wb_rsp.ack) begin
                        addr       <= addr + `PDU_ADDR_STEP;
                        words_left <= words_left - 1'b1;
                        if (words_left == 8'd1) begin
                            tx_buf    <= {REPLY_ACK, ZERO_WORD};
                            tx_left   <= 3'd1;
                            ret_state <= ST_IDLE;
                            state     <= ST_SEND;
                        end else begin
                            state <= ST_WDATA;
                        end
                    end
                end

                // Each word is sent before the next access starts
                ST_WB_READ: begin
                    if (wb_rsp.ack) begin
                        tx_buf     <= {wb_rsp.dat, 8'h00};
                        tx_left    <= 3'd4;
                        addr       <= addr + `PDU_ADDR_STEP;
                        words_left <= words_left - 1'b1;
                        ret_state  <= (words_left == 8'd1) ? ST_IDLE : ST_WB_READ;
                        state      <= ST_SEND;
                    end
                end

                ST_SEND: begin
                    if (tx_ready) begin
                        tx_buf  <= tx_buf << 8;
                        tx_left <= tx_left - 1'b1;
                        if (tx_left == 3'd1) begin
                            state <= ret_state;
                            if (ret_state == ST_RUN) begin
                                cpu_en <= 1'b1;
                            end
                        end
                    end
                end

                // Stopping commit is taken as executed
                ST_RUN: begin
                    if (stop_hit) begin
                        cpu_en    <= 1'b0;
                        tx_buf    <= {bp_hit ? REPLY_BP_HIT : REPLY_HALT, commit.pc};
                        tx_left   <= 3'd5;
                        ret_state <= ST_IDLE;
                        state     <= ST_SEND;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== source/pdu_top.sv ====
module pdu_top
    import pdu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    rxd,
    output logic    txd,
    output wb_req_t wb_req,
    input  wb_rsp_t wb_rsp,
    input  commit_t commit,
    output logic    cpu_en
);

    byte_stream_t rx_byte;
    byte_stream_t tx_byte;
    logic         tx_ready;
    logic         bp_set_en;
    logic         bp_clear;
    pdu_word_t    bp_set_pc;
    logic [1:0]   bp_slot;
    logic         bp_hit;

    // --------------------
    // Serial side
    // --------------------
    pdu_uart_rx u_uart_rx (
        .clk     (clk),
        .rst     (rst),
        .rxd     (rxd),
        .rx_byte (rx_byte)
    );

    pdu_uart_tx u_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_byte  (tx_byte),
        .tx_ready (tx_ready),
        .txd      (txd)
    );

    // --------------------
    // Debug core
    // --------------------
    pdu_bp_table u_bp_table (
        .clk       (clk),
        .rst       (rst),
        .bp_set_en (bp_set_en),
        .bp_clear  (bp_clear),
        .bp_set_pc (bp_set_pc),
        .commit    (commit),
        .bp_slot   (bp_slot),
        .bp_hit    (bp_hit)
    );

    pdu_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .rx_byte   (rx_byte),
        .tx_byte   (tx_byte),
        .tx_ready  (tx_ready),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .commit    (commit),
        .bp_hit    (bp_hit),
        .bp_slot   (bp_slot),
        .bp_set_en (bp_set_en),
        .bp_clear  (bp_clear),
        .bp_set_pc (bp_set_pc),
        .cpu_en    (cpu_en)
    );

endmodule

// ==== dv/pdu_clk_gen.sv ====
module pdu_clk_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RST_CYCLES = 3;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== dv/pdu_tb.sv ====
`include "pdu_defs.svh"

module pdu_tb
    import pdu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int        BIT_CLKS    = `PDU_BAUD_DIV;
    localparam int        RX_TIMEOUT  = 20000;
    localparam int        RST_TIMEOUT = 100;
    localparam int        MEM_WORDS   = 256;
    localparam pdu_word_t PC_START    = 32'h0000_1000;
    localparam pdu_word_t WR_BASE     = 32'h0000_0100;
    localparam pdu_word_t RD_BASE     = 32'h0000_0200;

    logic        clk;
    logic        rst;
    logic        rxd;
    logic        txd;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    commit_t     commit;
    logic        cpu_en;
    pdu_word_t   mem [MEM_WORDS];
    logic [31:0] rng_state = 32'h694a_da0e;
    pdu_word_t   cpu_pc;
    pdu_word_t   halt_pc;
    int          err_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    pdu_clk_gen u_clk_gen (.clk (clk), .rst (rst));

    pdu_top u_pdu_top (
        .clk    (clk),
        .rst    (rst),
        .rxd    (rxd),
        .txd    (txd),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .commit (commit),
        .cpu_en (cpu_en)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Preload pattern, a function of the byte address
    function automatic pdu_word_t fill_word(input pdu_word_t addr);
        return (addr * 32'h9E37_79B9) ^ 32'hC3C3_5A5A;
    endfunction

    // --------------------
    // Memory and CPU models
    // --------------------
    initial begin
        int   ack_wait;
        logic pending;
        ack_wait = 0;
        pending  = 1'b0;
        wb_rsp   = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[8'(i)] = fill_word(32'(i * 4));
        end
        forever begin
            @(negedge clk);
            if (rst || wb_rsp.ack) begin
                wb_rsp.ack = 1'b0;
                pending    = 1'b0;
            end else if (wb_req.cyc && wb_req.stb) begin
                if (!pending) begin
                    rng_state = xorshift32(rng_state);
                    ack_wait  = int'(rng_state[1:0]);
                    pending   = 1'b1;
                end
                if (ack_wait == 0) begin
                    if (wb_req.adr[31:10] != '0) begin
                        $display("Wishbone access outside the memory model at %h", wb_req.adr);
                        err_count++;
                    end else if (wb_req.we) begin
                        mem[wb_req.adr[9:2]] = wb_req.dat;
                    end else begin
                        wb_rsp.dat = mem[wb_req.adr[9:2]];
                    end
                    wb_rsp.ack = 1'b1;
                    pending    = 1'b0;
                end else begin
                    ack_wait--;
                end
            end
        end
    end

    // One commit per cycle while enabled, restarting at PC_START
    initial begin
        commit = '0;
        cpu_pc = PC_START;
        forever begin
            @(negedge clk);
            if (!rst && cpu_en) begin
                commit.valid = 1'b1;
                commit.pc    = cpu_pc;
                commit.halt  = (cpu_pc == halt_pc);
                cpu_pc       = cpu_pc + 32'd4;
            end else begin
                commit = '0;
                cpu_pc = PC_START;
            end
        end
    end

    // --------------------
    // Host UART and checks
    // --------------------
    task automatic abort_on_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic send_byte(input pdu_byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rxd   = frame[0];
            frame = frame >> 1;
            repeat (BIT_CLKS) @(negedge clk);
        end
    endtask

    task automatic send_word(input pdu_word_t w);
        pdu_word_t v;
        v = w;
        for (int i = 0; i < 4; i++) begin
            send_byte(v[31:24]);
            v = v << 8;
        end
    endtask

    task automatic recv_byte(output pdu_byte_t b);
        int waited;
        waited = 0;
        b      = '0;
        while (txd !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > RX_TIMEOUT) begin
                abort_on_timeout("a start bit on txd");
            end
        end
        repeat (BIT_CLKS / 2) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            b = {txd, b[7:1]};
        end
        repeat (BIT_CLKS) @(negedge clk);
        if (txd !== 1'b1) begin
            $display("Stop bit on txd is not high at %0t", $time);
            err_count++;
        end
    endtask

    task automatic recv_word(output pdu_word_t w);
        pdu_byte_t b;
        w = '0;
        for (int i = 0; i < 4; i++) begin
            recv_byte(b);
            w = {w[23:0], b};
        end
    endtask

    task automatic check_byte(input string name, input pdu_byte_t exp, input pdu_byte_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_word(input string name, input pdu_word_t exp, input pdu_word_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("[%0t] %s: pass", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t] %s: FAIL, %0d errors", $time, name, err_count - errs_before);
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_write_read();
        pdu_word_t wdata [4];
        pdu_word_t rdata;
        pdu_byte_t b;
        int        errs_before;
        errs_before = err_count;
        for (int i = 0; i < 4; i++) begin
            rng_state = xorshift32(rng_state);
            wdata[i]  = rng_state;
        end
        send_byte(CMD_WRITE);
        send_word(WR_BASE);
        send_byte(8'd4);
        for (int i = 0; i < 4; i++) begin
            send_word(wdata[i]);
        end
        recv_byte(b);
        check_byte("txd write reply", REPLY_ACK, b);
        send_byte(CMD_READ);
        send_word(WR_BASE);
        send_byte(8'd4);
        for (int i = 0; i < 4; i++) begin
            recv_word(rdata);
            check_word($sformatf("txd read word %0d", i), wdata[i], rdata);
            check_word($sformatf("mem word %0d", i), wdata[i], mem[WR_BASE[9:2] + 8'(i)]);
        end
        end_test("write_read", errs_before);
    endtask

    task automatic test_wait_states();
        pdu_word_t rdata;
        int        errs_before;
        errs_before = err_count;
        send_byte(CMD_READ);
        send_word(RD_BASE);
        send_byte(8'd8);
        for (int i = 0; i < 8; i++) begin
            recv_word(rdata);
            check_word($sformatf("txd read word %0d", i), fill_word(RD_BASE + i * 4), rdata);
        end
        check_bit("wb_req.cyc", 1'b0, wb_req.cyc);
        end_test("wait_states", errs_before);
    endtask

    task automatic test_bp_slots();
        pdu_byte_t b;
        int        errs_before;
        errs_before = err_count;
        for (int i = 0; i < 4; i++) begin
            send_byte(CMD_BP_SET);
            send_word(PC_START + 32'h10 * (i + 1));
            recv_byte(b);
            check_byte("txd bp set reply", (i < 3) ? pdu_byte_t'(i) : REPLY_FULL, b);
        end
        send_byte(CMD_BP_CLEAR);
        recv_byte(b);
        check_byte("txd bp clear reply", REPLY_ACK, b);
        send_byte(CMD_BP_SET);
        send_word(PC_START + 32'h80);
        recv_byte(b);
        check_byte("txd bp set reply", 8'd0, b);
        end_test("bp_slots", errs_before);
    endtask

    // Stop either on a breakpoint or on the model's halt commit
    task automatic test_run(input string name, input logic use_bp, input pdu_word_t stop_pc);
        pdu_byte_t b;
        pdu_word_t pc;
        int        errs_before;
        errs_before = err_count;
        send_byte(CMD_BP_CLEAR);
        recv_byte(b);
        check_byte("txd bp clear reply", REPLY_ACK, b);
        if (use_bp) begin
            send_byte(CMD_BP_SET);
            send_word(stop_pc);
            recv_byte(b);
            check_byte("txd bp set reply", 8'd0, b);
        end
        halt_pc = use_bp ? PC_START + 32'h100 : stop_pc;
        send_byte(CMD_RUN);
        recv_byte(b);
        check_byte("txd run reply", REPLY_ACK, b);
        recv_byte(b);
        check_byte("txd stop reply", use_bp ? REPLY_BP_HIT : REPLY_HALT, b);
        recv_word(pc);
        check_word("txd stop pc", stop_pc, pc);
        check_bit("cpu_en", 1'b0, cpu_en);
        end_test(name, errs_before);
    endtask

    task automatic test_unknown_op();
        pdu_byte_t b;
        pdu_word_t rdata;
        int        errs_before;
        errs_before = err_count;
        send_byte(8'h7E);
        recv_byte(b);
        check_byte("txd unknown op reply", REPLY_NAK, b);
        send_byte(CMD_READ);
        send_word(32'h0000_03FC);
        send_byte(8'd1);
        recv_word(rdata);
        check_word("txd read word 0", fill_word(32'h0000_03FC), rdata);
        end_test("unknown_op", errs_before);
    endtask

    initial begin
        int waited;
        waited  = 0;
        rxd     = 1'b1;
        halt_pc = '1;
        while (rst !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > RST_TIMEOUT) begin
                abort_on_timeout("reset release");
            end
        end
        repeat (4) @(negedge clk);
        test_write_read();
        test_wait_states();
        test_bp_slots();
        test_run("run_to_bp", 1'b1, PC_START + 32'h40);
        test_run("run_to_halt", 1'b0, PC_START + 32'h24);
        test_unknown_op();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+source
source/pdu_pkg.sv
source/pdu_uart_rx.sv
source/pdu_uart_tx.sv
source/pdu_bp_table.sv
source/pdu_ctrl.sv
source/pdu_top.sv
dv/pdu_clk_gen.sv
dv/pdu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator from all.f, run, and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    -f all.f --top-module pdu_tb -o pdu_sim

./obj_dir/pdu_sim > sim.log
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
